// File: verilog/cmPkg.sv
package cmPkg;

  typedef logic [13:0] cmAddrT;  // Program address
  typedef logic [23:0] cmWordT;  // Instruction word
  typedef logic [3:0]  cmOvlT;   // Overlay index
  typedef logic [7:0]  cmByteT;  // Boot stream byte

  localparam int BASE_DEPTH = 8192;  // Words in the base bank
  localparam int OVL_DEPTH  = 8192;  // Words in each overlay bank

  // Region codes on address bits 13:12
  localparam logic [1:0] RGN4K_BASE = 2'b00;
  localparam logic [1:0] RGN4K_OVL  = 2'b01;
  localparam logic [1:0] RGN8K_OVL  = 2'b10;

  typedef enum logic [1:0] {
    BOOT_IDLE,     // Waiting for bootStart
    BOOT_COLLECT,  // Gathering three bytes
    BOOT_WRITE,    // One write cycle into code memory
    BOOT_FINISH    // Done pulse
  } bootStateT;

endpackage

// File: verilog/cmBusIfs.sv
interface bootWrIf;
  import cmPkg::*;

  logic   wrValid;  // Write taken every cycle it is high
  cmAddrT wrAddr;
  cmWordT wrData;
  cmOvlT  wrOvl;

  modport source (
    output wrValid, wrAddr, wrData, wrOvl
  );

  modport sink (
    input wrValid, wrAddr, wrData, wrOvl
  );
endinterface

interface cmBankIf #(
  parameter int NUM_OVL = 8
);
  import cmPkg::*;

  logic [NUM_OVL:0]   cs;     // Bit 0 base bank, then overlays
  logic               we;
  cmAddrT             addr;
  cmWordT             wdata;
  cmWordT [NUM_OVL:0] rdata;  // One word per bank

  modport master (
    output cs, we, addr, wdata,
    input  rdata
  );
endinterface

// File: verilog/bootLoader.sv
module bootLoader #(
  parameter int BOOT_CREDITS = 4
) (
  input  logic          DSPCLK,
  input  logic          arstN,
  input  logic          bootStart,
  input  cmPkg::cmAddrT bootAddr,
  input  cmPkg::cmOvlT  bootOvl,
  input  logic [15:0]   bootLength,
  input  cmPkg::cmByteT bootByte,
  input  logic          bootByteValid,
  output logic          bootCredit,
  output logic          bootBusy,
  output logic          bootDone,
  bootWrIf.source       wr
);
  import cmPkg::*;

  localparam int PTR_W = (BOOT_CREDITS > 1) ? $clog2(BOOT_CREDITS) : 1;
  localparam int CNT_W = $clog2(BOOT_CREDITS + 1);

  cmByteT           fifoMem [BOOT_CREDITS];
  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] rdPtr;
  logic [CNT_W-1:0] fifoCnt;
  logic             pop;

  bootStateT   state;
  logic [1:0]  byteCnt;    // Bytes already in packReg
  logic [15:0] wordsLeft;  // Words still to write
  cmWordT      packReg;
  cmAddrT      addrReg;
  cmOvlT       ovlReg;

  function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(BOOT_CREDITS - 1)) ? '0 : p + 1'b1;
  endfunction

  assign pop = (state == BOOT_COLLECT) && (fifoCnt != '0);  // No pop in a write cycle

  always_ff @(posedge DSPCLK)
  begin
    if (bootByteValid)
      fifoMem[wrPtr] <= bootByte;
  end

  always_ff @(posedge DSPCLK or negedge arstN)
  begin
    if (!arstN)
    begin
      wrPtr      <= '0;
      rdPtr      <= '0;
      fifoCnt    <= '0;
      bootCredit <= 1'b0;
    end
    else
    begin
      if (bootByteValid)
        wrPtr <= nextPtr(wrPtr);
      if (pop)
        rdPtr <= nextPtr(rdPtr);
      fifoCnt    <= fifoCnt + CNT_W'(bootByteValid) - CNT_W'(pop);
      bootCredit <= pop;  // Returns one credit per removed byte
    end
  end

  always_ff @(posedge DSPCLK or negedge arstN)
  begin
    if (!arstN)
    begin
      state     <= BOOT_IDLE;
      byteCnt   <= '0;
      wordsLeft <= '0;
    end
    else
    begin
      case (state)
        BOOT_IDLE:
          if (bootStart)
          begin
            wordsLeft <= bootLength;
            byteCnt   <= '0;
            state     <= (bootLength == '0) ? BOOT_FINISH : BOOT_COLLECT;
          end
        BOOT_COLLECT:
          if (pop)
          begin
            byteCnt <= (byteCnt == 2'd2) ? 2'd0 : byteCnt + 2'd1;
            if (byteCnt == 2'd2)
              state <= BOOT_WRITE;  // Third byte arrives now
          end
        BOOT_WRITE:
        begin
          wordsLeft <= wordsLeft - 16'd1;
          state     <= (wordsLeft == 16'd1) ? BOOT_FINISH : BOOT_COLLECT;
        end
        default:
          state <= BOOT_IDLE;
      endcase
    end
  end

  always_ff @(posedge DSPCLK)
  begin
    if ((state == BOOT_IDLE) && bootStart)
    begin
      addrReg <= bootAddr;
      ovlReg  <= bootOvl;
    end
    else if (state == BOOT_WRITE)
      addrReg <= addrReg + 1'b1;  // Consecutive word addresses
    if (pop)
      packReg <= {packReg[15:0], fifoMem[rdPtr]};  // First byte ends up on top
  end

  assign wr.wrValid = (state == BOOT_WRITE);
  assign wr.wrAddr  = addrReg;
  assign wr.wrData  = packReg;
  assign wr.wrOvl   = ovlReg;
  assign bootBusy   = (state != BOOT_IDLE);
  assign bootDone   = (state == BOOT_FINISH);  // Cycle after the last write

  // Byte source must respect the credit count
  assert property (@(posedge DSPCLK) disable iff (!arstN)
    bootByteValid |-> (fifoCnt < CNT_W'(BOOT_CREDITS)));

endmodule

// File: verilog/cmSelect.sv
module cmSelect #(
  parameter int NUM_OVL = 8
) (
  input  logic          DSPCLK,
  input  logic          arstN,
  input  logic          pmBoundarySel,
  input  logic          fetchReq,
  input  cmPkg::cmAddrT fetchAddr,
  input  cmPkg::cmOvlT  fetchOvl,
  output logic          fetchGnt,
  output logic          fetchValid,
  output cmPkg::cmWordT fetchData,
  bootWrIf.sink         wr,
  cmBankIf.master       bank
);
  import cmPkg::*;

  cmAddrT           selAddr;
  cmOvlT            selOvl;
  logic             accEn;
  logic             baseRgn;
  logic             ovlRgn;
  logic [NUM_OVL:0] csNext;
  logic [NUM_OVL:0] oeReg;  // Registered read output enables

  // Boot writes always win the cycle
  assign fetchGnt = fetchReq && !wr.wrValid;
  assign accEn    = wr.wrValid || fetchGnt;
  assign selAddr  = wr.wrValid ? wr.wrAddr : fetchAddr;
  assign selOvl   = wr.wrValid ? wr.wrOvl : fetchOvl;

  always_comb
  begin
    if (pmBoundarySel)
    begin
      baseRgn = (selAddr[13:12] == RGN4K_BASE);  // 4K boundary
      ovlRgn  = (selAddr[13:12] == RGN4K_OVL);
    end
    else
    begin
      baseRgn = !selAddr[13];                    // 8K boundary
      ovlRgn  = (selAddr[13:12] == RGN8K_OVL);
    end
  end

  // Overlay index past NUM_OVL leaves every overlay bank unselected
  always_comb
  begin
    csNext    = '0;
    csNext[0] = baseRgn;
    for (int i = 0; i < NUM_OVL; i++)
      csNext[i+1] = ovlRgn && (selOvl == cmOvlT'(i));
  end

  assign bank.cs    = accEn ? csNext : '0;
  assign bank.we    = wr.wrValid;
  assign bank.addr  = selAddr;
  assign bank.wdata = wr.wrData;

  always_ff @(posedge DSPCLK or negedge arstN)
  begin
    if (!arstN)
    begin
      oeReg      <= '0;
      fetchValid <= 1'b0;
    end
    else
    begin
      oeReg      <= fetchGnt ? csNext : '0;  // Reads only
      fetchValid <= fetchGnt;
    end
  end

  always_comb
  begin
    fetchData = '0;  // Unmapped fetch returns zero
    for (int i = 0; i <= NUM_OVL; i++)
      if (oeReg[i])
        fetchData = fetchData | bank.rdata[i];
  end

  assert property (@(posedge DSPCLK) disable iff (!arstN)
    $onehot0(bank.cs));

endmodule

// File: verilog/codeMemBank.sv
module codeMemBank #(
  parameter int DEPTH = 8192
) (
  input  logic          DSPCLK,
  input  logic          sel,
  input  logic          we,
  input  cmPkg::cmAddrT addr,
  input  cmPkg::cmWordT wdata,
  output cmPkg::cmWordT rdata
);
  import cmPkg::*;

  localparam int IDX_W = $clog2(DEPTH);

  cmWordT           mem [DEPTH];
  logic [IDX_W-1:0] idx;

  assign idx = addr[IDX_W-1:0];  // Low address bits index the bank

  always_ff @(posedge DSPCLK)
  begin
    if (sel)
    begin
      if (we)
        mem[idx] <= wdata;
      else
        rdata <= mem[idx];  // Word visible one cycle later
    end
  end

endmodule

// File: verilog/codeMemSys.sv
module codeMemSys #(
  parameter int NUM_OVL      = 8,
  parameter int BOOT_CREDITS = 4
) (
  input  logic          DSPCLK,
  input  logic          arstN,
  input  logic          pmBoundarySel,
  input  logic          bootStart,
  input  cmPkg::cmAddrT bootAddr,
  input  cmPkg::cmOvlT  bootOvl,
  input  logic [15:0]   bootLength,
  input  cmPkg::cmByteT bootByte,
  input  logic          bootByteValid,
  output logic          bootCredit,
  output logic          bootBusy,
  output logic          bootDone,
  input  logic          fetchReq,
  input  cmPkg::cmAddrT fetchAddr,
  input  cmPkg::cmOvlT  fetchOvl,
  output logic          fetchGnt,
  output logic          fetchValid,
  output cmPkg::cmWordT fetchData
);
  import cmPkg::*;

  bootWrIf bootWr ();
  cmBankIf #(.NUM_OVL(NUM_OVL)) bankBus ();

  bootLoader #(.BOOT_CREDITS(BOOT_CREDITS)) loader_i (
    .DSPCLK        (DSPCLK),
    .arstN         (arstN),
    .bootStart     (bootStart),
    .bootAddr      (bootAddr),
    .bootOvl       (bootOvl),
    .bootLength    (bootLength),
    .bootByte      (bootByte),
    .bootByteValid (bootByteValid),
    .bootCredit    (bootCredit),
    .bootBusy      (bootBusy),
    .bootDone      (bootDone),
    .wr            (bootWr.source)
  );

  cmSelect #(.NUM_OVL(NUM_OVL)) select_i (
    .DSPCLK        (DSPCLK),
    .arstN         (arstN),
    .pmBoundarySel (pmBoundarySel),
    .fetchReq      (fetchReq),
    .fetchAddr     (fetchAddr),
    .fetchOvl      (fetchOvl),
    .fetchGnt      (fetchGnt),
    .fetchValid    (fetchValid),
    .fetchData     (fetchData),
    .wr            (bootWr.sink),
    .bank          (bankBus.master)
  );

  codeMemBank #(.DEPTH(BASE_DEPTH)) baseBank_i (
    .DSPCLK (DSPCLK),
    .sel    (bankBus.cs[0]),
    .we     (bankBus.we),
    .addr   (bankBus.addr),
    .wdata  (bankBus.wdata),
    .rdata  (bankBus.rdata[0])
  );

  for (genvar g = 0; g < NUM_OVL; g++)
  begin : ovlBankGen
    codeMemBank #(.DEPTH(OVL_DEPTH)) ovlBank_i (
      .DSPCLK (DSPCLK),
      .sel    (bankBus.cs[g+1]),     // Overlay g sits on select bit g+1
      .we     (bankBus.we),
      .addr   (bankBus.addr),
      .wdata  (bankBus.wdata),
      .rdata  (bankBus.rdata[g+1])
    );
  end

endmodule

// File: verification/codeMemChecker.sv
module codeMemChecker #(
  parameter int NUM_OVL      = 8,
  parameter int BOOT_CREDITS = 4
) (
  input  logic          DSPCLK,
  input  logic          arstN,
  input  logic          pmBoundarySel,
  input  logic          bootStart,
  input  cmPkg::cmAddrT bootAddr,
  input  cmPkg::cmOvlT  bootOvl,
  input  cmPkg::cmByteT bootByte,
  input  logic          bootByteValid,
  input  logic          bootCredit,
  input  logic          bootBusy,
  input  logic          bootDone,
  input  cmPkg::cmAddrT fetchAddr,
  input  cmPkg::cmOvlT  fetchOvl,
  input  logic          fetchGnt,
  input  logic          fetchValid,
  input  cmPkg::cmWordT fetchData,
  output int            errCount
);
  timeunit 1ns;
  timeprecision 100ps;
  import cmPkg::*;

  cmWordT refMem [int];  // Keyed by bank * BASE_DEPTH + entry
  cmAddrT wAddr;
  cmOvlT  wOvl;
  cmWordT pack;
  cmWordT expData;       // Reference word taken at grant time
  logic   gntLast;
  logic   busyExp;       // Loader busy from bootStart until bootDone
  int     byteIdx;
  int     credits;       // Credits still held by the byte source
  int     slot;

  // Bank 1 is the base bank, 2 and up the overlays, 0 means unmapped
  function automatic int refSlot(input cmAddrT a, input cmOvlT o, input logic mode4k);
    logic baseHit;
    logic ovlHit;
    baseHit = mode4k ? (a[13:12] == 2'b00) : !a[13];
    ovlHit  = mode4k ? (a[13:12] == 2'b01) : (a[13:12] == 2'b10);
    if (baseHit)
      return BASE_DEPTH + int'(a[12:0]);
    if (ovlHit && (int'(o) < NUM_OVL))
      return (int'(o) + 2) * BASE_DEPTH + int'(a[12:0]);
    return 0;
  endfunction

  function automatic cmWordT refRead(input cmAddrT a, input cmOvlT o, input logic mode4k);
    int s;
    s = refSlot(a, o, mode4k);
    if (s == 0)
      return '0;  // Unmapped fetch reads zero
    return refMem.exists(s) ? refMem[s] : 'x;
  endfunction

  initial errCount = 0;

  always @(negedge DSPCLK)
  begin
    if (!arstN)
    begin
      credits = BOOT_CREDITS;
      byteIdx = 0;
      gntLast = 1'b0;
      busyExp = 1'b0;
      if (fetchGnt || fetchValid || bootCredit || bootBusy || bootDone)
      begin
        $display("error at %0t: an output is active during reset", $time);
        errCount++;
      end
    end
    else
    begin
      credits = credits - int'(bootByteValid) + int'(bootCredit);
      if ((credits < 0) || (credits > BOOT_CREDITS))
      begin
        $display("error at %0t: credit count %0d is out of range", $time, credits);
        errCount++;
      end
      if (bootDone && (credits != BOOT_CREDITS))
      begin
        $display("error at %0t: only %0d credits back after bootDone", $time, credits);
        errCount++;
      end
      if (bootBusy !== busyExp)
      begin
        $display("mismatch at %0t: bootBusy expected %b actual %b",
                 $time, busyExp, bootBusy);
        errCount++;
      end
      if (bootStart && !busyExp)
      begin
        busyExp = 1'b1;
        wAddr   = bootAddr;
        wOvl    = bootOvl;
        byteIdx = 0;
      end
      else if (bootDone)
        busyExp = 1'b0;                 // Idle again next cycle
      if (bootByteValid)
      begin
        pack = {pack[15:0], bootByte};  // First byte of a word ends up on top
        byteIdx++;
        if (byteIdx == 3)
        begin
          slot = refSlot(wAddr, wOvl, pmBoundarySel);
          if (slot != 0)
            refMem[slot] = pack;        // Dropped when unmapped
          wAddr++;
          byteIdx = 0;
        end
      end
      if (fetchValid !== gntLast)
      begin
        $display("error at %0t: fetchValid did not follow a grant by one cycle", $time);
        errCount++;
      end
      else if (fetchValid && (fetchData !== expData))
      begin
        $display("mismatch at %0t: fetchData expected %h actual %h",
                 $time, expData, fetchData);
        errCount++;
      end
      gntLast = fetchGnt;
      if (fetchGnt)
        expData = refRead(fetchAddr, fetchOvl, pmBoundarySel);
    end
  end

endmodule

// File: verification/codeMemTb.sv
module codeMemTb;
  timeunit 1ns;
  timeprecision 100ps;
  import cmPkg::*;

  localparam int NUM_OVL       = 8;
  localparam int BOOT_CREDITS  = 4;
  localparam int TOTAL_WORDS   = 50;  // Words booted over all tests
  localparam int TOTAL_FETCHES = 73;
  localparam int LIMIT_CYCLES  = (3 * TOTAL_WORDS + TOTAL_FETCHES) * 20 + 100;

  logic        DSPCLK;
  logic        arstN;
  logic        pmBoundarySel;
  logic        bootStart;
  cmAddrT      bootAddr;
  cmOvlT       bootOvl;
  logic [15:0] bootLength;
  cmByteT      bootByte;
  logic        bootByteValid;
  logic        bootCredit;
  logic        bootBusy;
  logic        bootDone;
  logic        fetchReq;
  cmAddrT      fetchAddr;
  cmOvlT       fetchOvl;
  logic        fetchGnt;
  logic        fetchValid;
  cmWordT      fetchData;
  integer      seed;
  int          credits;  // Byte source view of its credits
  int          errCount;
  int          errBase;
  int          passCount;
  int          failCount;

  codeMemSys #(.NUM_OVL(NUM_OVL), .BOOT_CREDITS(BOOT_CREDITS)) dut_i (.*);

  codeMemChecker #(.NUM_OVL(NUM_OVL), .BOOT_CREDITS(BOOT_CREDITS)) chk_i (.*);

  initial
  begin
    DSPCLK = 1'b0;
    forever #2 DSPCLK = ~DSPCLK;
  end

  always @(negedge DSPCLK)
  begin
    if (!arstN)
      credits <= BOOT_CREDITS;
    else
      credits <= credits - int'(bootByteValid) + int'(bootCredit);
  end

  initial
  begin
    #(LIMIT_CYCLES * 4);
    $display("watchdog expired before the tests finished");
    $display("Testbench failed");
    $finish;
  end

  // Boot a block of random words, with random gaps between bytes
  task automatic bootRun(input logic mode4k, input cmAddrT a, input cmOvlT o,
                         input int len, input int gapMask);
    int sent;
    pmBoundarySel = mode4k;
    bootAddr      = a;
    bootOvl       = o;
    bootLength    = 16'(len);
    bootStart     = 1'b1;
    @(posedge DSPCLK);
    #1 bootStart = 1'b0;
    sent = 0;
    while (sent < 3 * len)
    begin
      bootByteValid = 1'b0;
      if ((credits > 0) && (($random(seed) & gapMask) == 0))
      begin
        bootByte      = cmByteT'($random(seed));
        bootByteValid = 1'b1;  // Spends one credit
        sent++;
      end
      @(posedge DSPCLK);
      #1;
    end
    bootByteValid = 1'b0;
    while (!bootDone)
    begin
      @(posedge DSPCLK);
      #1;
    end
    @(posedge DSPCLK);  // Loader back in idle
    #1;
  endtask

  task automatic fetchWord(input cmAddrT a, input cmOvlT o);
    fetchReq  = 1'b1;
    fetchAddr = a;
    fetchOvl  = o;
    do
      @(negedge DSPCLK);
    while (!fetchGnt);  // Held until granted
    @(posedge DSPCLK);
    #1 fetchReq = 1'b0;
  endtask

  task automatic fetchRange(input cmAddrT a, input cmOvlT o, input int n);
    for (int i = 0; i < n; i++)
      fetchWord(a + cmAddrT'(i), o);
  endtask

  task automatic finishTest(input string name);
    repeat (2) @(posedge DSPCLK);  // Let the last fetch return
    #1;
    if (errCount == errBase)
    begin
      passCount++;
      $display("test %s: ok", name);
    end
    else
    begin
      failCount++;
      $display("test %s: %0d errors", name, errCount - errBase);
    end
    errBase = errCount;
  endtask

  initial
  begin
    seed          = 32'hf61d_6098;
    arstN         = 1'b0;
    pmBoundarySel = 1'b1;
    bootStart     = 1'b0;
    bootAddr      = '0;
    bootOvl       = '0;
    bootLength    = '0;
    bootByte      = '0;
    bootByteValid = 1'b0;
    fetchReq      = 1'b0;
    fetchAddr     = '0;
    fetchOvl      = '0;
    errBase       = 0;
    passCount     = 0;
    failCount     = 0;
    repeat (3) @(posedge DSPCLK);
    #1 arstN = 1'b1;

    bootRun(1'b1, 14'h0100, 4'd0, 6, 1);  // 4K base
    fetchRange(14'h0100, 4'd0, 6);
    bootRun(1'b0, 14'h1800, 4'd0, 6, 1);  // 8K base, above 4K
    fetchRange(14'h1800, 4'd0, 6);
    finishTest("base boot both modes");

    bootRun(1'b0, 14'h2100, 4'd0, 4, 1);
    bootRun(1'b0, 14'h2100, 4'd3, 4, 1);
    bootRun(1'b0, 14'h2100, 4'd7, 4, 1);
    fetchRange(14'h2100, 4'd0, 4);
    fetchRange(14'h2100, 4'd3, 4);
    fetchRange(14'h2100, 4'd7, 4);
    fetchRange(14'h0100, 4'd0, 6);        // Base words untouched
    finishTest("overlay boot");

    bootRun(1'b0, 14'h0800, 4'd0, 12, 0);  // No gaps so the FIFO fills
    fetchRange(14'h0800, 4'd0, 12);
    finishTest("credit protocol");

    fork
      bootRun(1'b0, 14'h0400, 4'd0, 10, 3);
      begin
        fetchRange(14'h1800, 4'd0, 6);
        fetchRange(14'h2100, 4'd3, 4);
      end
    join
    fetchRange(14'h0400, 4'd0, 10);
    finishTest("fetch during boot");

    pmBoundarySel = 1'b1;
    fetchWord(14'h2000, 4'd0);
    fetchWord(14'h3FFF, 4'd0);
    fetchWord(14'h1040, 4'd8);
    pmBoundarySel = 1'b0;
    fetchWord(14'h3000, 4'd0);
    fetchWord(14'h2040, 4'd8);
    fetchWord(14'h2040, 4'd15);
    bootRun(1'b1, 14'h2100, 4'd3, 2, 1);   // Unmapped in 4K mode
    bootRun(1'b0, 14'h2100, 4'd11, 2, 1);  // Overlay index out of range
    fetchRange(14'h2100, 4'd3, 4);
    fetchWord(14'h2100, 4'd11);
    finishTest("unmapped access");

    $display("summary: %0d tests passed, %0d failed, %0d errors",
             passCount, failCount, errCount);
    if (failCount == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

// File: build.f
verilog/cmPkg.sv
verilog/cmBusIfs.sv
verilog/bootLoader.sv
verilog/cmSelect.sv
verilog/codeMemBank.sv
verilog/codeMemSys.sv
verification/codeMemChecker.sv
verification/codeMemTb.sv
